//--- hdl/mips_pkg.sv
// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
// shared types and constants of the MIPS pipeline
// opcode, funct and ALU control encodings
// pipeline register structs and operand forwarding
// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
package mips_pkg;

	typedef logic [31:0] word_t;
	typedef logic [31:0] pc_t;          // word address
	typedef logic [4:0]  reg_idx_t;
	typedef logic [12:0] dmem_addr_t;   // 8192 words
	typedef logic [3:0]  alu_ctrl_t;

	localparam int       NUM_REGS = 32;
	localparam word_t    SP_RESET = 32'h00001FFF;
	localparam reg_idx_t SP_REG   = 5'd29;

	localparam logic [5:0] OP_RTYPE = 6'd0;
	localparam logic [5:0] OP_BEQ   = 6'd4;
	localparam logic [5:0] OP_BNE   = 6'd5;
	localparam logic [5:0] OP_ADDI  = 6'd8;
	localparam logic [5:0] OP_ORI   = 6'd13;
	localparam logic [5:0] OP_LW    = 6'd35;
	localparam logic [5:0] OP_SW    = 6'd43;

	localparam logic [5:0] FN_SLL = 6'b000000;
	localparam logic [5:0] FN_SGT = 6'b000001;
	localparam logic [5:0] FN_SRL = 6'b000010;
	localparam logic [5:0] FN_SRA = 6'b000011;
	localparam logic [5:0] FN_ADD = 6'b100000;
	localparam logic [5:0] FN_SUB = 6'b100010;
	localparam logic [5:0] FN_AND = 6'b100100;
	localparam logic [5:0] FN_OR  = 6'b100101;
	localparam logic [5:0] FN_XOR = 6'b100110;
	localparam logic [5:0] FN_NOR = 6'b100111;
	localparam logic [5:0] FN_SLT = 6'b101010;

	localparam alu_ctrl_t ALU_AND = 4'b0000;
	localparam alu_ctrl_t ALU_OR  = 4'b0001;
	localparam alu_ctrl_t ALU_ADD = 4'b0010;
	localparam alu_ctrl_t ALU_XOR = 4'b0011;
	localparam alu_ctrl_t ALU_SLL = 4'b0100;
	localparam alu_ctrl_t ALU_SGT = 4'b0101;
	localparam alu_ctrl_t ALU_SUB = 4'b0110;
	localparam alu_ctrl_t ALU_SLT = 4'b0111;
	localparam alu_ctrl_t ALU_SRL = 4'b1000;
	localparam alu_ctrl_t ALU_SRA = 4'b1001;
	localparam alu_ctrl_t ALU_NOR = 4'b1100;

	localparam logic [1:0] AOP_ADD   = 2'b00; // lw, sw, addi
	localparam logic [1:0] AOP_OR    = 2'b01; // ori
	localparam logic [1:0] AOP_FUNCT = 2'b10; // R-type, decided by funct

	// all zero is a bubble
	typedef struct packed {
		logic       reg_write;
		logic       mem_to_reg;
		logic       mem_write;
		logic       mem_read;
		logic       alu_src;
		logic       reg_dst;
		logic [1:0] alu_op;
	} ex_ctrl_t;

	typedef struct packed {
		ex_ctrl_t   ctrl;
		word_t      rs_data;
		word_t      rt_data;
		word_t      imm;
		reg_idx_t   rs;
		reg_idx_t   rt;
		reg_idx_t   rd;
		logic [4:0] shamt;
		logic [5:0] funct;
	} id_ex_t;

	typedef struct packed {
		logic     reg_write;
		logic     mem_to_reg;
		logic     mem_write;
		logic     mem_read;
		word_t    alu_result;
		word_t    store_data;
		reg_idx_t dst;
	} ex_mem_t;

	// result offered by a later stage
	typedef struct packed {
		logic     reg_write;
		reg_idx_t dst;
		word_t    data;
	} fwd_src_t;

	// newest producer wins, EX/MEM before MEM/WB
	function automatic word_t fwd_select(reg_idx_t src, word_t rf_data,
		fwd_src_t mem_fwd, fwd_src_t wb_fwd);
		if (mem_fwd.reg_write && mem_fwd.dst != '0 && mem_fwd.dst == src)
		begin
			return mem_fwd.data;
		end
		if (wb_fwd.reg_write && wb_fwd.dst != '0 && wb_fwd.dst == src)
		begin
			return wb_fwd.data;
		end
		return rf_data;
	endfunction

endpackage

//--- hdl/fetch_stage.sv
// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
// instruction fetch
// PC register, next-PC select, IF/ID register
// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
`timescale 1ns/100ps

module fetch_stage
	import mips_pkg::*;
(
	input  logic  clk,
	input  logic  rst_n,
	input  logic  stall,
	input  logic  flush,
	input  logic  branch_taken,
	input  pc_t   branch_target,
	input  word_t imem_data,
	output pc_t   if_pc,
	output word_t id_instr,
	output pc_t   id_pc_next
);

	pc_t pc_plus1;

	assign pc_plus1 = if_pc + 32'd1; // one word per instruction

	always_ff @(posedge clk)
	begin
		if (!rst_n)
		begin
			if_pc      <= '0;
			id_instr   <= '0;
			id_pc_next <= '0;
		end
		else if (!stall) // stall holds PC and IF/ID
		begin
			if_pc <= branch_taken ? branch_target : pc_plus1;
			if (flush)
			begin
				id_instr   <= '0; // drop the wrong-path fetch
				id_pc_next <= '0;
			end
			else
			begin
				id_instr   <= imem_data;
				id_pc_next <= pc_plus1;
			end
		end
	end

endmodule

//--- hdl/reg_file.sv
// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
// 32 x 32 register file
// two read ports with write-through bypass
// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
`timescale 1ns/100ps

module reg_file
	import mips_pkg::*;
(
	input  logic     clk,
	input  logic     rst_n,
	input  reg_idx_t rs,
	input  reg_idx_t rt,
	input  fwd_src_t wb,
	output word_t    rs_data,
	output word_t    rt_data
);

	word_t regs [NUM_REGS];
	logic  wr_en;

	assign wr_en = wb.reg_write && wb.dst != '0; // r0 stays zero

	always_ff @(posedge clk)
	begin
		if (!rst_n)
		begin
			for (int i = 0; i < NUM_REGS; i++)
			begin
				regs[i] <= (i == SP_REG) ? SP_RESET : '0;
			end
		end
		else if (wr_en)
		begin
			regs[wb.dst] <= wb.data;
		end
	end

	// a read in the write cycle sees the new value
	assign rs_data = (wr_en && wb.dst == rs) ? wb.data : regs[rs];
	assign rt_data = (wr_en && wb.dst == rt) ? wb.data : regs[rt];

endmodule

//--- hdl/hazard_unit.sv
// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
// hazard detection
// load-use and branch-operand stalls, IF/ID flush
// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
`timescale 1ns/100ps

module hazard_unit
	import mips_pkg::*;
(
	input  word_t    id_instr,
	input  reg_idx_t ex_dst,
	input  logic     ex_reg_write,
	input  logic     ex_mem_read,
	input  reg_idx_t mem_dst,
	input  logic     mem_mem_read,
	input  logic     branch_taken,
	output logic     stall,
	output logic     flush
);

	logic [5:0] opcode;
	reg_idx_t   rs;
	reg_idx_t   rt;
	logic       is_branch;
	logic       uses_rs;
	logic       uses_rt;
	logic       ex_hit;
	logic       mem_hit;
	logic       load_use;
	logic       branch_ex;
	logic       branch_mem;

	assign opcode = id_instr[31:26];
	assign rs     = id_instr[25:21];
	assign rt     = id_instr[20:16];

	assign is_branch = opcode == OP_BEQ || opcode == OP_BNE;
	assign uses_rt   = opcode == OP_RTYPE || is_branch || opcode == OP_SW;
	assign uses_rs   = uses_rt || opcode == OP_ADDI || opcode == OP_ORI
		|| opcode == OP_LW;

	// rt of addi/ori/lw is a destination, never a source
	assign ex_hit  = ex_dst != '0 && ((uses_rs && ex_dst == rs) || (uses_rt && ex_dst == rt));
	assign mem_hit = mem_dst != '0 && ((uses_rs && mem_dst == rs) || (uses_rt && mem_dst == rt));

	assign load_use   = ex_mem_read && ex_hit;
	assign branch_ex  = is_branch && ex_reg_write && ex_hit;   // comparator has no EX path
	assign branch_mem = is_branch && mem_mem_read && mem_hit;  // load data not ready yet

	assign stall = load_use || branch_ex || branch_mem;
	assign flush = branch_taken && !stall;

endmodule

//--- hdl/decode_stage.sv
// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
// instruction decode
// main control, immediate extension, register file
// branch compare with forwarding, branch target
// ID/EX register with bubble insertion
// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
`timescale 1ns/100ps

module decode_stage
	import mips_pkg::*;
(
	input  logic     clk,
	input  logic     rst_n,
	input  logic     stall,
	input  word_t    id_instr,
	input  pc_t      id_pc_next,
	input  fwd_src_t mem_fwd,
	input  fwd_src_t wb_fwd,
	output logic     branch_taken,
	output pc_t      branch_target,
	output id_ex_t   id_ex
);

	logic [5:0] opcode;
	reg_idx_t   rs;
	reg_idx_t   rt;
	word_t      rs_data;
	word_t      rt_data;
	word_t      cmp_a;
	word_t      cmp_b;
	word_t      imm;
	ex_ctrl_t   ctrl;
	id_ex_t     id_ex_d;

	assign opcode = id_instr[31:26];
	assign rs     = id_instr[25:21];
	assign rt     = id_instr[20:16];

	reg_file i_reg_file (
		.clk     (clk),
		.rst_n   (rst_n),
		.rs      (rs),
		.rt      (rt),
		.wb      (wb_fwd),
		.rs_data (rs_data),
		.rt_data (rt_data)
	);

	always_comb
	begin
		ctrl = '0; // branches and unknown opcodes write nothing
		case (opcode)
			OP_RTYPE:
			begin
				ctrl.reg_write = 1'b1;
				ctrl.reg_dst   = 1'b1;
				ctrl.alu_op    = AOP_FUNCT;
			end
			OP_ADDI:
			begin
				ctrl.reg_write = 1'b1;
				ctrl.alu_src   = 1'b1;
				ctrl.alu_op    = AOP_ADD;
			end
			OP_ORI:
			begin
				ctrl.reg_write = 1'b1;
				ctrl.alu_src   = 1'b1;
				ctrl.alu_op    = AOP_OR;
			end
			OP_LW:
			begin
				ctrl.reg_write  = 1'b1;
				ctrl.mem_to_reg = 1'b1;
				ctrl.mem_read   = 1'b1;
				ctrl.alu_src    = 1'b1;
				ctrl.alu_op     = AOP_ADD;
			end
			OP_SW:
			begin
				ctrl.mem_write = 1'b1;
				ctrl.alu_src   = 1'b1;
				ctrl.alu_op    = AOP_ADD;
			end
			default:
			begin
				ctrl = '0;
			end
		endcase
	end

	// ori is zero extended, everything else sign extended
	assign imm = (opcode == OP_ORI) ? {16'h0000, id_instr[15:0]}
		: {{16{id_instr[15]}}, id_instr[15:0]};

	assign cmp_a = fwd_select(rs, rs_data, mem_fwd, wb_fwd);
	assign cmp_b = fwd_select(rt, rt_data, mem_fwd, wb_fwd);

	assign branch_taken = (opcode == OP_BEQ && cmp_a == cmp_b)
		|| (opcode == OP_BNE && cmp_a != cmp_b);
	assign branch_target = id_pc_next + imm;

	always_comb
	begin
		id_ex_d.ctrl    = stall ? '0 : ctrl; // bubble while stalled
		id_ex_d.rs_data = rs_data;
		id_ex_d.rt_data = rt_data;
		id_ex_d.imm     = imm;
		id_ex_d.rs      = rs;
		id_ex_d.rt      = rt;
		id_ex_d.rd      = id_instr[15:11];
		id_ex_d.shamt   = id_instr[10:6];
		id_ex_d.funct   = id_instr[5:0];
	end

	always_ff @(posedge clk)
	begin
		if (!rst_n)
		begin
			id_ex.ctrl <= '0;
		end
		else
		begin
			id_ex <= id_ex_d;
		end
	end

endmodule

//--- hdl/execute_stage.sv
// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
// execute stage
// operand forwarding, ALU control and ALU
// destination select and EX/MEM register
// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
`timescale 1ns/100ps

module execute_stage
	import mips_pkg::*;
(
	input  logic     clk,
	input  logic     rst_n,
	input  id_ex_t   id_ex,
	input  fwd_src_t mem_fwd,
	input  fwd_src_t wb_fwd,
	output reg_idx_t ex_dst,
	output ex_mem_t  ex_mem
);

	word_t     op_a;
	word_t     op_b_reg;
	word_t     op_b;
	alu_ctrl_t alu_ctrl;
	word_t     alu_result;
	ex_mem_t   ex_mem_d;

	assign op_a     = fwd_select(id_ex.rs, id_ex.rs_data, mem_fwd, wb_fwd);
	assign op_b_reg = fwd_select(id_ex.rt, id_ex.rt_data, mem_fwd, wb_fwd);
	assign op_b     = id_ex.ctrl.alu_src ? id_ex.imm : op_b_reg;

	always_comb
	begin
		case (id_ex.ctrl.alu_op)
			AOP_ADD: alu_ctrl = ALU_ADD;
			AOP_OR:  alu_ctrl = ALU_OR;
			AOP_FUNCT:
			begin
				case (id_ex.funct)
					FN_SLL:  alu_ctrl = ALU_SLL;
					FN_SGT:  alu_ctrl = ALU_SGT;
					FN_SRL:  alu_ctrl = ALU_SRL;
					FN_SRA:  alu_ctrl = ALU_SRA;
					FN_ADD:  alu_ctrl = ALU_ADD;
					FN_SUB:  alu_ctrl = ALU_SUB;
					FN_AND:  alu_ctrl = ALU_AND;
					FN_OR:   alu_ctrl = ALU_OR;
					FN_XOR:  alu_ctrl = ALU_XOR;
					FN_NOR:  alu_ctrl = ALU_NOR;
					FN_SLT:  alu_ctrl = ALU_SLT;
					default: alu_ctrl = ALU_AND;
				endcase
			end
			default: alu_ctrl = ALU_ADD;
		endcase
	end

	// shifts act on the second operand by shamt
	always_comb
	begin
		case (alu_ctrl)
			ALU_AND: alu_result = op_a & op_b;
			ALU_OR:  alu_result = op_a | op_b;
			ALU_ADD: alu_result = op_a + op_b;
			ALU_XOR: alu_result = op_a ^ op_b;
			ALU_NOR: alu_result = ~(op_a | op_b);
			ALU_SUB: alu_result = op_a - op_b;
			ALU_SLT: alu_result = {31'd0, $signed(op_a) < $signed(op_b)};
			ALU_SGT: alu_result = {31'd0, $signed(op_a) > $signed(op_b)};
			ALU_SLL: alu_result = op_b << id_ex.shamt;
			ALU_SRL: alu_result = op_b >> id_ex.shamt;
			ALU_SRA: alu_result = $signed(op_b) >>> id_ex.shamt;
			default: alu_result = '0;
		endcase
	end

	assign ex_dst = id_ex.ctrl.reg_dst ? id_ex.rd : id_ex.rt; // rd for R-type

	always_comb
	begin
		ex_mem_d.reg_write  = id_ex.ctrl.reg_write;
		ex_mem_d.mem_to_reg = id_ex.ctrl.mem_to_reg;
		ex_mem_d.mem_write  = id_ex.ctrl.mem_write;
		ex_mem_d.mem_read   = id_ex.ctrl.mem_read;
		ex_mem_d.alu_result = alu_result;
		ex_mem_d.store_data = op_b_reg; // forwarded rt for sw
		ex_mem_d.dst        = ex_dst;
	end

	always_ff @(posedge clk)
	begin
		if (!rst_n)
		begin
			ex_mem.reg_write  <= 1'b0;
			ex_mem.mem_to_reg <= 1'b0;
			ex_mem.mem_write  <= 1'b0;
			ex_mem.mem_read   <= 1'b0;
		end
		else
		begin
			ex_mem <= ex_mem_d;
		end
	end

endmodule

//--- hdl/writeback_stage.sv
// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
// write-back stage
// MEM/WB register and result select
// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
`timescale 1ns/100ps

module writeback_stage
	import mips_pkg::*;
(
	input  logic     clk,
	input  logic     rst_n,
	input  ex_mem_t  ex_mem,
	input  word_t    dmem_rdata,
	output fwd_src_t wb_fwd
);

	logic     wb_reg_write;
	logic     wb_mem_to_reg;
	reg_idx_t wb_dst;
	word_t    wb_alu_result;
	word_t    wb_load_data;

	always_ff @(posedge clk)
	begin
		if (!rst_n)
		begin
			wb_reg_write  <= 1'b0;
			wb_mem_to_reg <= 1'b0;
		end
		else
		begin
			wb_reg_write  <= ex_mem.reg_write;
			wb_mem_to_reg <= ex_mem.mem_to_reg;
		end
		wb_dst        <= ex_mem.dst;
		wb_alu_result <= ex_mem.alu_result;
		wb_load_data  <= dmem_rdata; // word read this cycle
	end

	assign wb_fwd.reg_write = wb_reg_write;
	assign wb_fwd.dst       = wb_dst;
	assign wb_fwd.data      = wb_mem_to_reg ? wb_load_data : wb_alu_result;

endmodule

//--- hdl/mips_pipeline.sv
// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
// five-stage MIPS pipeline top level
// stage wiring and memory ports
// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
`timescale 1ns/100ps

module mips_pipeline
	import mips_pkg::*;
(
	input  logic       clk,
	input  logic       rst_n,
	output pc_t        imem_addr,
	input  word_t      imem_data,
	output dmem_addr_t dmem_addr,
	output logic       dmem_we,
	output logic       dmem_re,
	output word_t      dmem_wdata,
	input  word_t      dmem_rdata
);

	logic     stall;
	logic     flush;
	logic     branch_taken;
	pc_t      branch_target;
	word_t    id_instr;
	pc_t      id_pc_next;
	id_ex_t   id_ex;
	reg_idx_t ex_dst;
	ex_mem_t  ex_mem;
	fwd_src_t mem_fwd;
	fwd_src_t wb_fwd;

	assign mem_fwd.reg_write = ex_mem.reg_write;
	assign mem_fwd.dst       = ex_mem.dst;
	assign mem_fwd.data      = ex_mem.alu_result;

	assign dmem_addr  = ex_mem.alu_result[$bits(dmem_addr_t)-1:0];
	assign dmem_we    = ex_mem.mem_write;
	assign dmem_re    = ex_mem.mem_read;
	assign dmem_wdata = ex_mem.store_data;

	fetch_stage i_fetch_stage (
		.clk           (clk),
		.rst_n         (rst_n),
		.stall         (stall),
		.flush         (flush),
		.branch_taken  (branch_taken),
		.branch_target (branch_target),
		.imem_data     (imem_data),
		.if_pc         (imem_addr),
		.id_instr      (id_instr),
		.id_pc_next    (id_pc_next)
	);

	hazard_unit i_hazard_unit (
		.id_instr     (id_instr),
		.ex_dst       (ex_dst),
		.ex_reg_write (id_ex.ctrl.reg_write),
		.ex_mem_read  (id_ex.ctrl.mem_read),
		.mem_dst      (ex_mem.dst),
		.mem_mem_read (ex_mem.mem_read),
		.branch_taken (branch_taken),
		.stall        (stall),
		.flush        (flush)
	);

	decode_stage i_decode_stage (
		.clk           (clk),
		.rst_n         (rst_n),
		.stall         (stall),
		.id_instr      (id_instr),
		.id_pc_next    (id_pc_next),
		.mem_fwd       (mem_fwd),
		.wb_fwd        (wb_fwd),
		.branch_taken  (branch_taken),
		.branch_target (branch_target),
		.id_ex         (id_ex)
	);

	execute_stage i_execute_stage (
		.clk     (clk),
		.rst_n   (rst_n),
		.id_ex   (id_ex),
		.mem_fwd (mem_fwd),
		.wb_fwd  (wb_fwd),
		.ex_dst  (ex_dst),
		.ex_mem  (ex_mem)
	);

	writeback_stage i_writeback_stage (
		.clk        (clk),
		.rst_n      (rst_n),
		.ex_mem     (ex_mem),
		.dmem_rdata (dmem_rdata),
		.wb_fwd     (wb_fwd)
	);

endmodule

//--- test/mips_pipeline_assertions.sv
// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
// concurrent checks on the MIPS pipeline ports
// strobe exclusion, reset quiet, PC hold on stall
// bind into the top level
// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
`timescale 1ns/100ps

module mips_pipeline_assertions
	import mips_pkg::*;
(
	input logic clk,
	input logic rst_n,
	input logic stall,
	input pc_t  imem_addr,
	input logic dmem_we,
	input logic dmem_re
);

	int violations = 0;

	strobes_exclusive: assert property (@(posedge clk) disable iff (!rst_n)
		!(dmem_we && dmem_re))
	else
	begin
		$error("data memory read and write strobes high together");
		violations++;
	end

	// registers cleared one edge into reset
	quiet_in_reset: assert property (@(posedge clk) !rst_n |=> !dmem_we && !dmem_re)
	else
	begin
		$error("memory strobe active during reset");
		violations++;
	end

	pc_held_on_stall: assert property (@(posedge clk) disable iff (!rst_n)
		stall |=> $stable(imem_addr))
	else
	begin
		$error("instruction address moved during a stall");
		violations++;
	end

endmodule

bind mips_pipeline mips_pipeline_assertions i_assertions (
	.clk       (clk),
	.rst_n     (rst_n),
	.stall     (stall),
	.imem_addr (imem_addr),
	.dmem_we   (dmem_we),
	.dmem_re   (dmem_re)
);

//--- test/tb_mips_pipeline.sv
// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
// testbench for the five-stage MIPS pipeline
// instruction and data memories, clock and reset
// directed and seeded random programs
// ISA reference model and in-order store checker
// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
`timescale 1ns/100ps

module tb_mips_pipeline
	import mips_pkg::*;
;

	localparam int    IMEM_WORDS    = 256;
	localparam int    DMEM_WORDS    = 8192;
	localparam int    STORE_TIMEOUT = 200;
	localparam int    QUIET_CYCLES  = 50;
	localparam word_t SELF_LOOP     = {OP_BEQ, 5'd0, 5'd0, 16'hFFFF}; // beq r0,r0,-1

	logic       clk = 1'b0;
	logic       rst_n;
	pc_t        imem_addr;
	word_t      imem_data;
	dmem_addr_t dmem_addr;
	logic       dmem_we;
	logic       dmem_re;
	word_t      dmem_wdata;
	word_t      dmem_rdata;

	word_t      imem [IMEM_WORDS];
	word_t      dmem [DMEM_WORDS];
	word_t      ref_mem [DMEM_WORDS];
	word_t      prog [$];
	dmem_addr_t exp_addr [$];
	word_t      exp_data [$];
	dmem_addr_t got_addr [$];
	word_t      got_data [$];
	integer     seed;

	mips_pipeline i_dut (
		.clk        (clk),
		.rst_n      (rst_n),
		.imem_addr  (imem_addr),
		.imem_data  (imem_data),
		.dmem_addr  (dmem_addr),
		.dmem_we    (dmem_we),
		.dmem_re    (dmem_re),
		.dmem_wdata (dmem_wdata),
		.dmem_rdata (dmem_rdata)
	);

	initial
	begin
		forever #2 clk = ~clk;
	end

	assign imem_data  = (imem_addr < IMEM_WORDS) ? imem[imem_addr[7:0]] : '0; // nop outside
	assign dmem_rdata = (dmem_re === 1'b1) ? dmem[dmem_addr] : 'x; // only valid on a read

	always @(posedge clk)
	begin
		if (dmem_we === 1'b1)
		begin
			dmem[dmem_addr] <= dmem_wdata;
		end
	end

	// sampled mid-cycle, written at the next rising edge
	always @(negedge clk)
	begin
		if (dmem_we === 1'b1)
		begin
			got_addr.push_back(dmem_addr);
			got_data.push_back(dmem_wdata);
		end
	end

	// a failed bound assertion ends the run
	always @(posedge clk)
	begin
		if (i_dut.i_assertions.violations != 0)
		begin
			abort_run("a bound assertion on the pipeline failed");
		end
	end

	function automatic word_t rtype(logic [5:0] funct, reg_idx_t rd, reg_idx_t rs,
		reg_idx_t rt, logic [4:0] shamt);
		return {OP_RTYPE, rs, rt, rd, shamt, funct};
	endfunction

	function automatic word_t itype(logic [5:0] op, reg_idx_t rt, reg_idx_t rs,
		logic [15:0] imm);
		return {op, rs, rt, imm};
	endfunction

	function automatic word_t fill_word(int a);
		return word_t'(a) * 32'h9E3779B1 + 32'h0F0F1234;
	endfunction

	// runs the program in imem on ref_mem, expected stores in order
	function automatic int reference_run();
		word_t      regs [NUM_REGS];
		pc_t        pc;
		word_t      ins;
		word_t      a;
		word_t      b;
		word_t      simm;
		word_t      res;
		word_t      sum;
		dmem_addr_t addr;
		reg_idx_t   rt;
		int         steps;
		for (int i = 0; i < NUM_REGS; i++)
		begin
			regs[i] = (i == SP_REG) ? SP_RESET : '0;
		end
		pc    = '0;
		steps = 0;
		while (steps < 4000)
		begin
			ins = (pc < IMEM_WORDS) ? imem[pc[7:0]] : '0;
			if (ins == SELF_LOOP)
			begin
				break;
			end
			a    = regs[ins[25:21]];
			b    = regs[ins[20:16]];
			rt   = ins[20:16];
			simm = {{16{ins[15]}}, ins[15:0]};
			sum  = a + simm;
			addr = sum[12:0];
			pc   = pc + 32'd1;
			case (ins[31:26])
				OP_RTYPE:
				begin
					case (ins[5:0])
						FN_ADD:  res = a + b;
						FN_SUB:  res = a - b;
						FN_AND:  res = a & b;
						FN_OR:   res = a | b;
						FN_XOR:  res = a ^ b;
						FN_NOR:  res = ~(a | b);
						FN_SLT:  res = ($signed(a) < $signed(b)) ? 32'd1 : 32'd0;
						FN_SGT:  res = ($signed(a) > $signed(b)) ? 32'd1 : 32'd0;
						FN_SLL:  res = b << ins[10:6];
						FN_SRL:  res = b >> ins[10:6];
						FN_SRA:  res = $signed(b) >>> ins[10:6];
						default: res = a & b;
					endcase
					regs[ins[15:11]] = res;
				end
				OP_ADDI: regs[rt] = sum;
				OP_ORI:  regs[rt] = a | {16'h0000, ins[15:0]};
				OP_LW:   regs[rt] = ref_mem[addr];
				OP_SW:
				begin
					ref_mem[addr] = b;
					exp_addr.push_back(addr);
					exp_data.push_back(b);
				end
				OP_BEQ:  pc = (a == b) ? pc + simm : pc;
				OP_BNE:  pc = (a != b) ? pc + simm : pc;
				default: res = '0;
			endcase
			regs[0] = '0; // r0 stays zero
			steps++;
		end
		return exp_addr.size();
	endfunction

	task automatic abort_run(input string reason);
		$display("%s", reason);
		$display("Regression failed");
		$fatal(1, "stopped at first error");
	endtask

	task automatic verify_addr(input string name, input dmem_addr_t got, input dmem_addr_t exp);
		if (got !== exp)
		begin
			abort_run($sformatf("Fail %s got %h expected %h", name, got, exp));
		end
	endtask

	task automatic check_word(input string name, input word_t got, input word_t exp);
		if (got !== exp)
		begin
			abort_run($sformatf("Fail %s got %h expected %h", name, got, exp));
		end
	endtask

	task automatic run_program(input string name);
		int         n;
		int         cycles;
		dmem_addr_t a;
		word_t      d;
		prog.push_back(SELF_LOOP);
		rst_n = 1'b0;
		for (int i = 0; i < IMEM_WORDS; i++)
		begin
			imem[i] = (i < prog.size()) ? prog[i] : '0;
		end
		for (int i = 0; i < DMEM_WORDS; i++)
		begin
			dmem[i]    = fill_word(i);
			ref_mem[i] = fill_word(i);
		end
		exp_addr.delete();
		exp_data.delete();
		got_addr.delete();
		got_data.delete();
		n = reference_run();
		repeat (16) @(negedge clk);
		rst_n = 1'b1;
		for (int i = 0; i < n; i++)
		begin
			cycles = 0;
			while (got_addr.size() == 0 && cycles < STORE_TIMEOUT)
			begin
				@(posedge clk);
				cycles++;
			end
			if (got_addr.size() == 0)
			begin
				abort_run($sformatf("timeout in %s waiting for store %0d of %0d",
					name, i + 1, n));
			end
			a = got_addr.pop_front();
			d = got_data.pop_front();
			verify_addr($sformatf("dmem_addr (%s store %0d)", name, i), a, exp_addr[i]);
			check_word($sformatf("dmem_wdata (%s store %0d)", name, i), d, exp_data[i]);
		end
		cycles = 0;
		while (got_addr.size() == 0 && cycles < QUIET_CYCLES) // nothing after the last store
		begin
			@(posedge clk);
			cycles++;
		end
		if (got_addr.size() != 0)
		begin
			abort_run($sformatf("unexpected extra store in %s to address %h",
				name, got_addr[0]));
		end
		prog.delete();
		@(negedge clk);
	endtask

	task automatic forwarding_program();
		prog.push_back(itype(OP_ADDI, 1, 0, 16'd5));
		prog.push_back(itype(OP_ADDI, 2, 1, 16'd7)); // from EX/MEM
		prog.push_back(rtype(FN_ADD, 3, 1, 2, 0));   // MEM/WB and EX/MEM
		prog.push_back(rtype(FN_SUB, 4, 3, 1, 0));   // r1 via register bypass
		prog.push_back(itype(OP_ORI, 5, 4, 16'h8001));
		prog.push_back(rtype(FN_AND, 6, 5, 3, 0));
		prog.push_back(rtype(FN_OR, 7, 6, 2, 0));
		prog.push_back(rtype(FN_XOR, 8, 7, 5, 0));
		prog.push_back(rtype(FN_NOR, 9, 8, 1, 0));
		prog.push_back(itype(OP_SW, 9, 0, 16'd100)); // store data forwarded
		for (int r = 1; r < 9; r++)
		begin
			prog.push_back(itype(OP_SW, reg_idx_t'(r), 0, 16'(100 + r)));
		end
	endtask

	task automatic load_use_program();
		prog.push_back(itype(OP_LW, 1, 0, 16'd10));
		prog.push_back(rtype(FN_ADD, 2, 1, 1, 0)); // load-use
		prog.push_back(itype(OP_SW, 2, 0, 16'd200));
		prog.push_back(itype(OP_LW, 3, 0, 16'd11));
		prog.push_back(itype(OP_SW, 3, 0, 16'd201)); // store of a fresh load
		prog.push_back(itype(OP_LW, 4, 0, 16'd12));
		prog.push_back(itype(OP_ADDI, 5, 4, 16'hFFFD));
		prog.push_back(itype(OP_LW, 6, 0, 16'd13));
		prog.push_back(rtype(FN_SUB, 7, 6, 5, 0));
		prog.push_back(itype(OP_SW, 5, 0, 16'd202));
		prog.push_back(itype(OP_SW, 7, 0, 16'd203));
		prog.push_back(itype(OP_SW, 2, 0, 16'd300));
		prog.push_back(itype(OP_LW, 8, 0, 16'd300)); // read back
		prog.push_back(itype(OP_SW, 8, 0, 16'd204));
		prog.push_back(itype(OP_LW, 9, 0, 16'd14));
		prog.push_back(itype(OP_LW, 10, 9, 16'd0)); // loaded base address
		prog.push_back(itype(OP_SW, 10, 0, 16'd205));
	endtask

	task automatic branch_program();
		prog.push_back(itype(OP_ADDI, 1, 0, 16'd3));
		prog.push_back(itype(OP_ADDI, 2, 0, 16'd3));
		prog.push_back(itype(OP_ADDI, 3, 0, 16'd4));
		prog.push_back(itype(OP_BEQ, 2, 1, 16'd1)); // taken
		prog.push_back(itype(OP_SW, 1, 0, 16'd50)); // flushed
		prog.push_back(itype(OP_SW, 2, 0, 16'd51));
		prog.push_back(itype(OP_BNE, 2, 1, 16'd1)); // not taken
		prog.push_back(itype(OP_SW, 3, 0, 16'd52));
		prog.push_back(itype(OP_BNE, 3, 1, 16'd1)); // taken
		prog.push_back(itype(OP_SW, 1, 0, 16'd53));
		prog.push_back(itype(OP_BEQ, 3, 1, 16'd1)); // not taken
		prog.push_back(itype(OP_SW, 3, 0, 16'd54));
		prog.push_back(itype(OP_ADDI, 4, 0, 16'd3));
		prog.push_back(itype(OP_ADDI, 5, 5, 16'd2));
		prog.push_back(itype(OP_ADDI, 4, 4, 16'hFFFF));
		prog.push_back(itype(OP_BNE, 0, 4, 16'hFFFD)); // backward loop, three passes
		prog.push_back(itype(OP_SW, 5, 0, 16'd55));
		prog.push_back(itype(OP_SW, 4, 0, 16'd56));
	endtask

	task automatic branch_hazard_program();
		prog.push_back(itype(OP_ADDI, 1, 0, 16'd9));
		prog.push_back(itype(OP_ADDI, 2, 0, 16'd9));
		prog.push_back(itype(OP_BEQ, 2, 1, 16'd1)); // r2 still in EX
		prog.push_back(itype(OP_SW, 1, 0, 16'd60));
		prog.push_back(itype(OP_SW, 2, 0, 16'd61));
		prog.push_back(itype(OP_LW, 3, 0, 16'd20));
		prog.push_back(itype(OP_BEQ, 0, 3, 16'd1)); // load in EX, then MEM
		prog.push_back(itype(OP_SW, 3, 0, 16'd62));
		prog.push_back(itype(OP_LW, 4, 0, 16'd20));
		prog.push_back(itype(OP_BNE, 3, 4, 16'd1));
		prog.push_back(itype(OP_SW, 4, 0, 16'd63));
		prog.push_back(itype(OP_LW, 5, 0, 16'd21));
		prog.push_back(itype(OP_BNE, 3, 5, 16'd1));
		prog.push_back(itype(OP_SW, 5, 0, 16'd64));
		prog.push_back(rtype(FN_SUB, 6, 5, 3, 0));
		prog.push_back(itype(OP_BEQ, 0, 6, 16'd1));
		prog.push_back(itype(OP_SW, 6, 0, 16'd65));
		prog.push_back(itype(OP_SW, 5, 0, 16'd66));
	endtask

	task automatic alu_program();
		prog.push_back(itype(OP_SW, SP_REG, 0, 16'd70)); // stack pointer reset value
		prog.push_back(itype(OP_ADDI, 1, 0, 16'hFFEC));  // -20
		prog.push_back(itype(OP_ADDI, 2, 0, 16'd7));
		prog.push_back(rtype(FN_SLL, 3, 0, 1, 4));
		prog.push_back(rtype(FN_SRL, 4, 0, 1, 3));
		prog.push_back(rtype(FN_SRA, 5, 0, 1, 3));
		prog.push_back(rtype(FN_SLT, 6, 1, 2, 0));
		prog.push_back(rtype(FN_SGT, 7, 1, 2, 0));
		prog.push_back(rtype(FN_SLT, 8, 2, 1, 0));
		prog.push_back(rtype(FN_SGT, 9, 2, 1, 0));
		prog.push_back(itype(OP_ORI, 10, 0, 16'h8000));  // zero extended
		prog.push_back(itype(OP_ADDI, 11, 0, 16'h8000)); // sign extended
		prog.push_back(rtype(FN_SRA, 12, 0, 11, 31));
		prog.push_back(rtype(FN_SUB, 13, 2, 1, 0));
		for (int r = 3; r < 14; r++)
		begin
			prog.push_back(itype(OP_SW, reg_idx_t'(r), 0, 16'(70 + r)));
		end
	endtask

	task automatic random_program();
		logic [5:0] functs [11];
		word_t      r;
		word_t      s;
		int         kind;
		functs = '{FN_ADD, FN_SUB, FN_AND, FN_OR, FN_XOR, FN_NOR,
			FN_SLT, FN_SGT, FN_SLL, FN_SRL, FN_SRA};
		for (int i = 0; i < 40; i++)
		begin
			r    = $random(seed);
			s    = $random(seed);
			kind = int'(r[31:27]) % 15;
			if (kind < 11)
			begin
				prog.push_back(rtype(functs[kind], reg_idx_t'(r[2:0]) + 5'd1,
					reg_idx_t'(r[5:3]), reg_idx_t'(r[8:6]), s[20:16]));
			end
			else if (kind == 11)
			begin
				prog.push_back(itype(OP_ADDI, reg_idx_t'(r[2:0]) + 5'd1,
					reg_idx_t'(r[5:3]), s[15:0]));
			end
			else if (kind == 12)
			begin
				prog.push_back(itype(OP_ORI, reg_idx_t'(r[2:0]) + 5'd1,
					reg_idx_t'(r[5:3]), s[15:0]));
			end
			else if (kind == 13)
			begin
				prog.push_back(itype(OP_LW, reg_idx_t'(r[2:0]) + 5'd1, 0, {6'd0, s[9:0]}));
			end
			else
			begin
				prog.push_back(itype(OP_SW, reg_idx_t'(r[8:6]), 0, 16'd1024 + s[8:0]));
			end
		end
		for (int n = 0; n < NUM_REGS; n++)
		begin
			prog.push_back(itype(OP_SW, reg_idx_t'(n), 0, 16'(2000 + n))); // dump all registers
		end
	endtask

	initial
	begin
		seed  = 32'h996c;
		rst_n = 1'b0;
		forwarding_program();
		run_program("forwarding");
		load_use_program();
		run_program("load-use");
		branch_program();
		run_program("branches");
		branch_hazard_program();
		run_program("branch hazards");
		alu_program();
		run_program("alu operations");
		random_program();
		run_program("random");
		if (i_dut.i_assertions.violations == 0)
		begin
			$display("Regression passed");
			$finish;
		end
		else
		begin
			$display("%0d assertion violations seen", i_dut.i_assertions.violations);
			$display("Regression failed");
			$fatal(1, "assertion violations");
		end
	end

endmodule

//--- sim.f
hdl/mips_pkg.sv
hdl/fetch_stage.sv
hdl/reg_file.sv
hdl/hazard_unit.sv
hdl/decode_stage.sv
hdl/execute_stage.sv
hdl/writeback_stage.sv
hdl/mips_pipeline.sv
test/mips_pipeline_assertions.sv
test/tb_mips_pipeline.sv

//--- Bender.yml
package:
  name: mips_pipeline

sources:
  - files:
      - hdl/mips_pkg.sv
      - hdl/fetch_stage.sv
      - hdl/reg_file.sv
      - hdl/hazard_unit.sv
      - hdl/decode_stage.sv
      - hdl/execute_stage.sv
      - hdl/writeback_stage.sv
      - hdl/mips_pipeline.sv
  - target: test
    files:
      - test/mips_pipeline_assertions.sv
      - test/tb_mips_pipeline.sv
